// ==== project.f ====
isa_pkg.sv
core_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
cpu_top.sv
tb_clock_gen.sv
tb_top.sv

// ==== Bender.yml ====
package:
  name: cpu16_core

sources:
  - isa_pkg.sv
  - core_pkg.sv
  - fetch_stage.sv
  - reg_file.sv
  - decode_stage.sv
  - execute_stage.sv
  - cpu_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_top.sv

// ==== tb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_top;

  localparam int period_ns    = 10;
  localparam int reset_cycles = 10;
  localparam int num_tests    = 6;
  // per test: a full memory load and run, plus reset, pauses and sweep
  localparam int watchdog_cycles =
    4 * num_tests * (2 * core_pkg::imem_depth + reset_cycles + 64);

  logic               hlt;
  logic               arst_n;
  logic               reset_req;
  logic               run;
  logic               prog_we;
  core_pkg::pc_t      prog_addr;
  isa_pkg::instr_t    prog_data;
  isa_pkg::reg_addr_t dbg_addr;
  core_pkg::word_t    dbg_data;
  logic               halted;

  isa_pkg::instr_t prog [core_pkg::imem_depth];   // program image under test
  int              prog_len;
  core_pkg::word_t exp_regs [isa_pkg::num_regs];  // from the reference model
  logic [15:0]     lfsr = 16'd58;
  int              errs;          // errors of the running test
  int              total_errs;
  int              tests_failed;
  event            sweep_req;
  event            sweep_done;

  tb_clock_gen u_clk (.reset_req, .hlt, .arst_n);

  cpu_top u_dut (.hlt, .arst_n, .run, .prog_we, .prog_addr, .prog_data,
                 .dbg_addr, .dbg_data, .halted);

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////
  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[14:0], fb};
    end
    return v;
  endfunction

  function automatic isa_pkg::instr_t enc_rrr(input logic [3:0] op,
      input isa_pkg::reg_addr_t rd, input isa_pkg::reg_addr_t rs0,
      input isa_pkg::reg_addr_t rs1);
    return {op, rd, rs0, rs1};
  endfunction

  function automatic isa_pkg::instr_t enc_imm(input logic [3:0] op,
      input isa_pkg::reg_addr_t rd, input isa_pkg::imm_t imm);
    return {op, rd, imm};
  endfunction

  task automatic emit(input isa_pkg::instr_t instr);
    prog[prog_len] = instr;
    prog_len++;
  endtask

  // random pick among add..srl, codes 0..6
  task automatic emit_alu(input isa_pkg::reg_addr_t rd, input isa_pkg::reg_addr_t rs0,
      input isa_pkg::reg_addr_t rs1);
    logic [2:0] sel;
    sel = take_bits(3);
    if (sel == 3'd7) sel = 3'd4;   // xor gets the spare slot
    emit(enc_rrr({1'b0, sel}, rd, rs0, rs1));
  endtask

  // every program opens by giving r1..r15 a full 16-bit value
  task automatic start_program();
    prog_len = 0;
    for (int r = 1; r < isa_pkg::num_regs; r++) begin
      emit(enc_imm(isa_pkg::op_lli, r, take_bits(8)));
      emit(enc_imm(isa_pkg::op_lhi, r, take_bits(8)));   // back-to-back on rd
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  // runs the image in program order up to op_hlt
  function automatic void interpret();
    core_pkg::word_t r [isa_pkg::num_regs];
    core_pkg::word_t a;
    core_pkg::word_t b;
    core_pkg::word_t y;
    logic [3:0]      op;
    logic [3:0]      rd;
    logic            wr;
    logic            stop;
    for (int i = 0; i < isa_pkg::num_regs; i++) r[i] = '0;
    stop = 1'b0;
    for (int pc = 0; pc < prog_len && !stop; pc++) begin
      op = prog[pc][15:12];
      rd = prog[pc][11:8];
      a  = r[prog[pc][7:4]];
      b  = r[prog[pc][3:0]];
      y  = '0;
      wr = 1'b1;
      case (op)
        isa_pkg::op_add : y = a + b;
        isa_pkg::op_sub : y = a - b;
        isa_pkg::op_and : y = a & b;
        isa_pkg::op_or  : y = a | b;
        isa_pkg::op_xor : y = a ^ b;
        isa_pkg::op_sll : y = a << b[3:0];
        isa_pkg::op_srl : y = a >> b[3:0];
        isa_pkg::op_lli : y = {8'h00, prog[pc][7:0]};
        isa_pkg::op_lhi : y = {prog[pc][7:0], r[rd][7:0]};   // old low byte of rd
        isa_pkg::op_hlt : begin
          wr   = 1'b0;
          stop = 1'b1;
        end
        default : wr = 1'b0;   // unassigned codes do nothing
      endcase
      if (wr && rd != 4'd0) r[rd] = y;
    end
    for (int i = 0; i < isa_pkg::num_regs; i++) exp_regs[i] = r[i];
  endfunction

  ////////////////////////////////////////
  // sequencing
  ////////////////////////////////////////
  task automatic step();
    @(posedge hlt);
    #1;   // inputs move just after the edge
  endtask

  task automatic apply_reset();
    run = 1'b0;
    step();
    reset_req = 1'b1;
    step();
    reset_req = 1'b0;
    wait (arst_n === 1'b1);
    step();
    a_halted_cleared : assert (halted === 1'b0) else begin
      $display("CHECK FAILED at %0t ns: halted expected 0, actual %b", $time, halted);
      errs++;
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      prog_we   = 1'b1;
      prog_addr = i;
      prog_data = prog[i];
      step();
    end
    prog_we = 1'b0;
  endtask

  // reset, load, run to halt, then sweep the registers
  task automatic run_program(input int num, input string name, input int pauses,
      input int hold);
    int limit;
    apply_reset();
    load_program();
    interpret();
    limit = 4 * prog_len + 20;
    run   = 1'b1;
    repeat (pauses) begin
      repeat (take_bits(2) + 2) step();
      run = 1'b0;           // freeze fetch, pipe drains
      repeat (take_bits(3) + 3) step();
      run = 1'b1;
    end
    for (int n = 0; n < limit && halted !== 1'b1; n++) step();
    a_halt_seen : assert (halted === 1'b1) else begin
      $display("test %0d: halted never rose within %0d cycles of run", num, limit);
      errs++;
    end
    repeat (hold) begin
      step();
      a_halted_held : assert (halted === 1'b1) else begin
        $display("CHECK FAILED at %0t ns: halted expected 1, actual %b", $time, halted);
        errs++;
      end
    end
    -> sweep_req;
    @(sweep_done);
    run = 1'b0;
    $display("test %0d %s: %0d errors", num, name, errs);
    if (errs != 0) tests_failed++;
    total_errs += errs;
    errs = 0;
  endtask

  // compares the stored registers after halt
  always begin
    @(sweep_req);
    for (int i = 0; i < isa_pkg::num_regs; i++) begin
      @(posedge hlt);
      #1 dbg_addr = i;
      @(negedge hlt);   // mid cycle, dbg_data settled
      a_reg_value : assert (dbg_data === exp_regs[i]) else begin
        $display("CHECK FAILED at %0t ns: dbg_data[%0d] expected %h, actual %h",
                 $time, i, exp_regs[i], dbg_data);
        errs++;
      end
    end
    -> sweep_done;
  end

  initial begin
    isa_pkg::reg_addr_t prev, prev2, cur;
    reset_req    = 1'b0;
    run          = 1'b0;
    prog_we      = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    dbg_addr     = '0;
    errs         = 0;
    total_errs   = 0;
    tests_failed = 0;
    wait (arst_n === 1'b1);   // power-on reset done
    step();

    start_program();
    repeat (24) emit_alu(take_bits(4), take_bits(4), take_bits(4));
    emit(enc_imm(isa_pkg::op_hlt, 0, 8'h00));
    run_program(1, "alu_random", 0, 0);

    // each op reads the last result and the one before it
    start_program();
    prev  = take_bits(4);
    prev2 = take_bits(4);
    repeat (20) begin
      cur = take_bits(4);
      emit_alu(cur, prev, prev2);
      prev2 = prev;
      prev  = cur;
    end
    emit(enc_imm(isa_pkg::op_lli, 5, 8'h3c));
    emit(enc_rrr(isa_pkg::op_add, 6, 5, 5));
    emit(enc_imm(isa_pkg::op_lhi, 5, 8'hc3));
    emit(enc_rrr(isa_pkg::op_sub, 7, 5, 6));   // r5 back-to-back, r6 one apart
    emit(enc_imm(isa_pkg::op_hlt, 0, 8'h00));
    run_program(2, "dependencies", 0, 0);

    start_program();
    emit(enc_imm(isa_pkg::op_lli, 0, 8'h5a));
    emit(enc_rrr(isa_pkg::op_or, 3, 0, 1));    // r0 read right behind its write
    emit(enc_imm(isa_pkg::op_lhi, 0, 8'ha5));
    emit(enc_rrr(isa_pkg::op_add, 0, 1, 2));
    emit(enc_rrr(isa_pkg::op_xor, 4, 0, 0));
    emit(enc_rrr(isa_pkg::op_sub, 0, 3, 4));
    emit(enc_rrr(isa_pkg::op_add, 5, 0, 2));
    emit(enc_imm(isa_pkg::op_hlt, 0, 8'h00));
    run_program(3, "r0_writes", 0, 0);

    start_program();
    repeat (8) emit_alu(take_bits(4), take_bits(4), take_bits(4));
    emit(enc_imm(4'hc, 1, 8'hff));             // unassigned opcode
    emit(enc_imm(isa_pkg::op_hlt, 0, 8'h00));
    for (int r = 1; r < 11; r++) emit(enc_imm(isa_pkg::op_lli, r, 8'hee));
    run_program(4, "after_halt", 0, 20);

    // core is still halted here, reset must clear it
    start_program();
    repeat (20) emit_alu(take_bits(4), take_bits(4), take_bits(4));
    emit(enc_imm(isa_pkg::op_hlt, 0, 8'h00));
    run_program(5, "reset_rerun", 0, 0);

    start_program();
    repeat (24) emit_alu(take_bits(4), take_bits(4), take_bits(4));
    emit(enc_imm(isa_pkg::op_hlt, 0, 8'h00));
    run_program(6, "run_pause", 3, 0);

    $display("summary: %0d tests, %0d failed, %0d errors", num_tests, tests_failed,
             total_errs);
    if (tests_failed == 0 && total_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // hang guard
  initial begin
    #(watchdog_cycles * period_ns);
    $display("watchdog: run still going after %0d cycles, a test hung", watchdog_cycles);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

// free running clock and active-low reset for the testbench
module tb_clock_gen (
  input  wire  reset_req,   // rising edge starts a new reset
  output logic hlt,
  output logic arst_n
);

  localparam int period_ns    = 10;
  localparam int reset_cycles = 10;

  initial begin
    hlt = 1'b0;
    forever #(period_ns / 2) hlt = ~hlt;
  end

  initial begin
    arst_n = 1'b0;   // power-on reset
    forever begin
      repeat (reset_cycles) @(posedge hlt);
      #1 arst_n = 1'b1;   // release off the edge
      @(posedge reset_req);
      arst_n = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// four stage core, fetch / decode+rf read / execute / write-back
module cpu_top (
  input  wire                     hlt,
  input  wire                     arst_n,
  input  wire                     run,
  input  wire                     prog_we,
  input  wire core_pkg::pc_t      prog_addr,
  input  wire isa_pkg::instr_t    prog_data,
  input  wire isa_pkg::reg_addr_t dbg_addr,
  output core_pkg::word_t         dbg_data,
  output logic                    halted
);

  // fetch -> decode
  logic               fd_valid;
  isa_pkg::instr_t    fd_instr;
  logic               stop_fetch;
  // decode <-> rf
  isa_pkg::reg_addr_t rd_addr0, rd_addr1;
  core_pkg::word_t    rd_data0, rd_data1;
  // decode -> execute
  logic               dx_valid;
  isa_pkg::opcode_e   dx_op;
  isa_pkg::reg_addr_t dx_rd;
  core_pkg::word_t    dx_a, dx_b;
  isa_pkg::imm_t      dx_imm;
  // execute -> decode forwarding, execute -> rf write-back
  logic               ex_fwd_valid;
  isa_pkg::reg_addr_t ex_fwd_rd;
  core_pkg::word_t    ex_fwd_data;
  logic               wb_we;
  isa_pkg::reg_addr_t wb_addr;
  core_pkg::word_t    wb_data;

  fetch_stage u_fetch (.hlt, .arst_n, .run, .stop_fetch, .prog_we, .prog_addr,
                       .prog_data, .fd_valid, .fd_instr);

  decode_stage u_decode (.hlt, .arst_n, .fd_valid, .fd_instr, .rd_addr0, .rd_addr1,
                         .rd_data0, .rd_data1, .ex_fwd_valid, .ex_fwd_rd, .ex_fwd_data,
                         .stop_fetch, .dx_valid, .dx_op, .dx_rd, .dx_a, .dx_b, .dx_imm);

  reg_file u_rf (.hlt, .arst_n, .rd_addr0, .rd_addr1, .rd_data0, .rd_data1,
                 .wb_we, .wb_addr, .wb_data, .dbg_addr, .dbg_data);

  execute_stage u_exec (.hlt, .arst_n, .dx_valid, .dx_op, .dx_rd, .dx_a, .dx_b,
                        .dx_imm, .ex_fwd_valid, .ex_fwd_rd, .ex_fwd_data, .wb_we,
                        .wb_addr, .wb_data, .halted);

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

// alu, write-back register and halt retirement
module execute_stage (
  input  wire                     hlt,
  input  wire                     arst_n,
  input  wire                     dx_valid,
  input  wire isa_pkg::opcode_e   dx_op,
  input  wire isa_pkg::reg_addr_t dx_rd,
  input  wire core_pkg::word_t    dx_a,
  input  wire core_pkg::word_t    dx_b,
  input  wire isa_pkg::imm_t      dx_imm,
  output logic                    ex_fwd_valid,
  output isa_pkg::reg_addr_t      ex_fwd_rd,
  output core_pkg::word_t         ex_fwd_data,
  output logic                    wb_we,
  output isa_pkg::reg_addr_t      wb_addr,
  output core_pkg::word_t         wb_data,
  output logic                    halted
);

  core_pkg::word_t alu_y;
  logic            alu_wr;    // opcode writes rd
  logic [core_pkg::shamt_w-1:0] shamt;

  assign shamt = dx_b[core_pkg::shamt_w-1:0];

  ////////////////////////////////////////
  // alu
  ////////////////////////////////////////
  always_comb begin
    alu_wr = 1'b1;
    case (dx_op)
      isa_pkg::op_add : alu_y = dx_a + dx_b;
      isa_pkg::op_sub : alu_y = dx_a - dx_b;
      isa_pkg::op_and : alu_y = dx_a & dx_b;
      isa_pkg::op_or  : alu_y = dx_a | dx_b;
      isa_pkg::op_xor : alu_y = dx_a ^ dx_b;
      isa_pkg::op_sll : alu_y = dx_a << shamt;
      isa_pkg::op_srl : alu_y = dx_a >> shamt;
      isa_pkg::op_lli : alu_y = {8'h00, dx_imm};        // zero extend
      isa_pkg::op_lhi : alu_y = {dx_imm, dx_a[7:0]};    // keep old low byte
      default : begin   // op_hlt and unused codes
        alu_y  = '0;
        alu_wr = 1'b0;
      end
    endcase
  end

  // r0 results are never forwarded
  assign ex_fwd_valid = dx_valid && alu_wr && (dx_rd != '0);
  assign ex_fwd_rd    = dx_rd;
  assign ex_fwd_data  = alu_y;

  always_ff @(posedge hlt or negedge arst_n) begin
    if (!arst_n) begin
      wb_we  <= 1'b0;
      halted <= 1'b0;
    end else begin
      wb_we <= dx_valid && alu_wr;   // r0 writes reach the rf and die there
      if (dx_valid && (dx_op == isa_pkg::op_hlt)) halted <= 1'b1;
    end
  end

  always_ff @(posedge hlt) begin
    wb_addr <= dx_rd;
    wb_data <= alu_y;
  end

  // decode squash must keep every later op out of write-back
  a_quiet_after_halt : assert property (@(posedge hlt) disable iff (!arst_n)
    halted |-> !wb_we);

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

// field split, operand read with forwarding, decode/execute register
module decode_stage (
  input  wire                     hlt,
  input  wire                     arst_n,
  input  wire                     fd_valid,
  input  wire isa_pkg::instr_t    fd_instr,
  output isa_pkg::reg_addr_t      rd_addr0,
  output isa_pkg::reg_addr_t      rd_addr1,
  input  wire core_pkg::word_t    rd_data0,
  input  wire core_pkg::word_t    rd_data1,
  input  wire                     ex_fwd_valid,   // already excludes r0
  input  wire isa_pkg::reg_addr_t ex_fwd_rd,
  input  wire core_pkg::word_t    ex_fwd_data,
  output logic                    stop_fetch,
  output logic                    dx_valid,
  output isa_pkg::opcode_e        dx_op,
  output isa_pkg::reg_addr_t      dx_rd,
  output core_pkg::word_t         dx_a,
  output core_pkg::word_t         dx_b,
  output isa_pkg::imm_t           dx_imm
);

  isa_pkg::opcode_e   op;
  isa_pkg::reg_addr_t rd;
  isa_pkg::reg_addr_t rs0;
  isa_pkg::reg_addr_t rs1;
  isa_pkg::imm_t      imm;
  core_pkg::word_t    a_val;     // operand after forwarding
  core_pkg::word_t    b_val;
  logic               hlt_seen;  // op_hlt already passed, squash the rest

  ////////////////////////////////////////
  // field extraction
  ////////////////////////////////////////
  assign op  = isa_pkg::opcode_e'(fd_instr[isa_pkg::op_lsb +: isa_pkg::op_w]);
  assign rd  = fd_instr[isa_pkg::rd_lsb  +: isa_pkg::reg_aw];
  assign rs0 = fd_instr[isa_pkg::rs0_lsb +: isa_pkg::reg_aw];
  assign rs1 = fd_instr[isa_pkg::rs1_lsb +: isa_pkg::reg_aw];
  assign imm = fd_instr[isa_pkg::imm_lsb +: isa_pkg::imm_w];

  // lhi merges into its own rd, so read rd on port 0
  assign rd_addr0 = (op == isa_pkg::op_lhi) ? rd : rs0;
  assign rd_addr1 = rs1;   // don't care for lli/lhi

  assign stop_fetch = fd_valid && (op == isa_pkg::op_hlt) && !hlt_seen;

  ////////////////////////////////////////
  // operand forwarding
  ////////////////////////////////////////
  always_comb begin
    a_val = rd_data0;   // rf already bypasses the write-back slot
    b_val = rd_data1;
    if (ex_fwd_valid && (ex_fwd_rd == rd_addr0)) a_val = ex_fwd_data;
    if (ex_fwd_valid && (ex_fwd_rd == rd_addr1)) b_val = ex_fwd_data;
  end

  ////////////////////////////////////////
  // decode/execute register
  ////////////////////////////////////////
  always_ff @(posedge hlt or negedge arst_n) begin
    if (!arst_n) begin
      dx_valid <= 1'b0;
      hlt_seen <= 1'b0;
    end else begin
      dx_valid <= fd_valid && !hlt_seen;   // op_hlt itself goes through
      if (stop_fetch) hlt_seen <= 1'b1;
    end
  end

  always_ff @(posedge hlt) begin
    dx_op  <= op;
    dx_rd  <= rd;
    dx_a   <= a_val;
    dx_b   <= b_val;
    dx_imm <= imm;
  end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

// 16 x 16 register file, two read ports, one write port
module reg_file (
  input  wire                    hlt,
  input  wire                    arst_n,     // only used to qualify the checks
  input  wire isa_pkg::reg_addr_t rd_addr0,
  input  wire isa_pkg::reg_addr_t rd_addr1,
  output core_pkg::word_t        rd_data0,
  output core_pkg::word_t        rd_data1,
  input  wire                    wb_we,
  input  wire isa_pkg::reg_addr_t wb_addr,
  input  wire core_pkg::word_t   wb_data,
  input  wire isa_pkg::reg_addr_t dbg_addr,
  output core_pkg::word_t        dbg_data
);

  core_pkg::word_t regs [isa_pkg::num_regs];   // slot 0 never written

  // r0 first, then the write in flight, then storage
  function automatic core_pkg::word_t read_port(input isa_pkg::reg_addr_t addr);
    if (addr == '0) return '0;
    if (wb_we && (wb_addr == addr)) return wb_data;   // write-through
    return regs[addr];
  endfunction

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////
  always_ff @(posedge hlt) begin
    if (wb_we && (wb_addr != '0)) begin   // r0 writes dropped here
      regs[wb_addr] <= wb_data;
    end
  end

  ////////////////////////////////////////
  // read ports
  ////////////////////////////////////////
  always_comb begin
    rd_data0 = read_port(rd_addr0);
    rd_data1 = read_port(rd_addr1);
    // debug sees the stored array only, no bypass
    dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];
  end

  // a write aimed at r0 leaves the slot untouched
  a_r0_never_stored : assert property (@(posedge hlt) disable iff (!arst_n)
    (wb_we && (wb_addr == '0)) |=> (regs[0] === $past(regs[0])));

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

// program store, pc and the fetch/decode register
module fetch_stage (
  input  wire                  hlt,
  input  wire                  arst_n,
  input  wire                  run,          // level, fetch only while high
  input  wire                  stop_fetch,   // pulse from decode on op_hlt
  input  wire                  prog_we,
  input  wire core_pkg::pc_t   prog_addr,
  input  wire isa_pkg::instr_t prog_data,
  output logic                 fd_valid,
  output isa_pkg::instr_t      fd_instr
);

  isa_pkg::instr_t imem [core_pkg::imem_depth];   // loaded from outside
  core_pkg::pc_t   pc;
  logic            stopped;    // sticky after op_hlt, cleared by reset only
  logic            fetch_en;

  // the cycle that sees stop_fetch already fetches nothing
  assign fetch_en = run && !stopped && !stop_fetch;

  ////////////////////////////////////////
  // program write port
  ////////////////////////////////////////
  always_ff @(posedge hlt) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  ////////////////////////////////////////
  // pc and valid
  ////////////////////////////////////////
  always_ff @(posedge hlt or negedge arst_n) begin
    if (!arst_n) begin
      pc       <= '0;
      stopped  <= 1'b0;
      fd_valid <= 1'b0;
    end else begin
      if (stop_fetch) stopped <= 1'b1;
      fd_valid <= fetch_en;            // bubble when frozen or halting
      if (fetch_en) pc <= pc + 1'b1;   // wraps at imem_depth
    end
  end

  always_ff @(posedge hlt) begin
    if (fetch_en) fd_instr <= imem[pc];   // holds while frozen
  end

  // loading must happen with the core idle
  a_no_load_while_run : assert property (@(posedge hlt) disable iff (!arst_n)
    prog_we |-> !run);

endmodule

`default_nettype wire

// ==== core_pkg.sv ====
`default_nettype none

// microarchitecture sizes
package core_pkg;

  ////////////////////////////////////////
  // datapath
  ////////////////////////////////////////
  localparam int word_w  = 16;
  localparam int shamt_w = $clog2(word_w);   // shifts use low 4 bits of rs1

  typedef logic [word_w-1:0] word_t;

  ////////////////////////////////////////
  // instruction memory
  ////////////////////////////////////////
  localparam int imem_depth = 64;                  // words
  localparam int pc_w       = $clog2(imem_depth);  // 6 bits

  typedef logic [pc_w-1:0] pc_t;

endpackage

`default_nettype wire

// ==== isa_pkg.sv ====
`default_nettype none

// instruction set view of the core
package isa_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////
  localparam int instr_w  = 16;   // one instruction per word
  localparam int op_w     = 4;
  localparam int reg_aw   = 4;    // register number width
  localparam int imm_w    = 8;
  localparam int num_regs = 16;   // r0 hardwired to zero

  // bit positions inside an instruction word
  localparam int op_lsb  = 12;    // opcode in 15..12
  localparam int rd_lsb  = 8;     // destination in 11..8
  localparam int rs0_lsb = 4;     // first source in 7..4
  localparam int rs1_lsb = 0;     // second source in 3..0
  localparam int imm_lsb = 0;     // imm8 overlays rs0/rs1

  typedef logic [instr_w-1:0] instr_t;
  typedef logic [reg_aw-1:0]  reg_addr_t;
  typedef logic [imm_w-1:0]   imm_t;

  ////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////
  // codes 4'ha..4'hf are unassigned and run as no-ops
  typedef enum logic [op_w-1:0] {
    op_add = 4'h0,   // rd = rs0 + rs1
    op_sub = 4'h1,   // rd = rs0 - rs1
    op_and = 4'h2,
    op_or  = 4'h3,
    op_xor = 4'h4,
    op_sll = 4'h5,   // shift amount from rs1[3:0]
    op_srl = 4'h6,   // logical, zero fill
    op_lli = 4'h7,   // rd = {8'h00, imm8}
    op_lhi = 4'h8,   // rd = {imm8, rd[7:0]}
    op_hlt = 4'h9    // stop fetch, raise halted once drained
  } opcode_e;

endpackage

`default_nettype wire
